// ==== filelist.f ====
mem_pkg.sv
port_ctrl_if.sv
sram_like_handshake.sv
rdata_latch.sv
mem_port.sv
pipe_control.sv
mem_pipeline.sv
tb_mem_pipeline.sv

// ==== mem_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_pipeline (
    input  logic           clk,
    input  logic           resetn,

    // instruction bus
    output logic           inst_req,
    output mem_pkg::word_t inst_addr,
    input  mem_pkg::word_t inst_rdata,
    input  logic           inst_addr_ok,
    input  logic           inst_data_ok,

    // data bus
    output logic           data_req,
    output logic           data_wr,
    output mem_pkg::word_t data_addr,
    output mem_pkg::word_t data_wdata,
    input  mem_pkg::word_t data_rdata,
    input  logic           data_addr_ok,
    input  logic           data_data_ok,

    // retire trace
    output logic           debug_wb_valid,
    output mem_pkg::word_t debug_wb_pc,
    output mem_pkg::word_t debug_wb_data
);
    import mem_pkg::*;

    retire_t retire;

    port_ctrl_if imem_if ();
    port_ctrl_if dmem_if ();

    // fetch side never writes
    mem_port imem_port (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (imem_if.port),
        .req     (inst_req),
        .wr      (),
        .addr    (inst_addr),
        .wdata   (),
        .rdata   (inst_rdata),
        .addr_ok (inst_addr_ok),
        .data_ok (inst_data_ok)
    );

    mem_port dmem_port (
        .clk     (clk),
        .resetn  (resetn),
        .ctrl    (dmem_if.port),
        .req     (data_req),
        .wr      (data_wr),
        .addr    (data_addr),
        .wdata   (data_wdata),
        .rdata   (data_rdata),
        .addr_ok (data_addr_ok),
        .data_ok (data_data_ok)
    );

    pipe_control u_pipe_control (
        .clk          (clk),
        .resetn       (resetn),
        .imem         (imem_if.ctrl),
        .dmem         (dmem_if.ctrl),
        .retire       (retire),
        .retire_valid (debug_wb_valid)
    );

    assign debug_wb_pc   = retire.pc;
    assign debug_wb_data = retire.data;

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // one bus word, used for addresses, data and transaction tags
    typedef logic [31:0] word_t;

    // toy instruction set
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_JUMP  = 2'd3
    } op_t;

    // imm is store data, addr is a load/store byte address or a jump target
    typedef struct packed {
        op_t         op;
        logic [13:0] imm;
        logic [15:0] addr;
    } instr_t;

    // writeback record for the debug ports
    typedef struct packed {
        word_t pc;
        word_t data;
    } retire_t;

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // byte distance between sequential instructions
    localparam word_t PC_STEP = 32'd4;

    // tag the handshake holds before any transaction was served
    localparam word_t ID_NONE = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== mem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_port (
    input  logic           clk,
    input  logic           resetn,
    port_ctrl_if.port      ctrl,
    output logic           req,
    output logic           wr,
    output mem_pkg::word_t addr,
    output mem_pkg::word_t wdata,
    input  mem_pkg::word_t rdata,
    input  logic           addr_ok,
    input  logic           data_ok
);

    sram_like_handshake u_handshake (
        .clk       (clk),
        .resetn    (resetn),
        .need_req  (ctrl.need_req),
        .unique_id (ctrl.unique_id),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .req       (req),
        .busy      (ctrl.busy)
    );

    rdata_latch u_rdata_latch (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (ctrl.stall),
        .flush   (ctrl.flush),
        .data_ok (data_ok),
        .in      (rdata),
        .out     (ctrl.rdata),
        .done    (ctrl.done)
    );

    // write flag only shown alongside a request
    assign wr = req && ctrl.wr;

    // address and write data stay stable while the stage waits
    assign addr  = ctrl.addr;
    assign wdata = ctrl.wdata;

endmodule

`default_nettype wire

// ==== pipe_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_control (
    input  logic             clk,
    input  logic             resetn,
    port_ctrl_if.ctrl        imem,
    port_ctrl_if.ctrl        dmem,
    output mem_pkg::retire_t retire,
    output logic             retire_valid
);
    import mem_pkg::*;

    // fetch
    word_t  pc;
    word_t  fetch_id;
    logic   redir_pend;
    word_t  redir_pc;

    // execute
    logic   x_valid;
    word_t  x_pc;
    instr_t x_instr;

    // memory
    logic   m_valid;
    word_t  m_pc;
    instr_t m_instr;
    word_t  inst_count;

    logic   f_ready;
    logic   f_kill;
    logic   f_go;
    logic   f_redir;
    logic   x_jump;
    logic   jump_fire;
    word_t  jump_pc;
    logic   m_load;
    logic   m_store;
    logic   m_mem;
    logic   m_wait;
    word_t  store_data;

    assign m_load     = m_valid && (m_instr.op == OP_LOAD);
    assign m_store    = m_valid && (m_instr.op == OP_STORE);
    assign m_mem      = m_load || m_store;
    assign m_wait     = m_mem && !dmem.done;
    assign store_data = {18'b0, m_instr.imm};

    assign x_jump    = x_valid && (x_instr.op == OP_JUMP);
    assign jump_pc   = {16'b0, x_instr.addr};
    assign jump_fire = x_jump && !m_wait;

    // fetched word is wrong path while a redirect is open
    assign f_ready = !imem.busy;
    assign f_kill  = jump_fire || redir_pend;
    assign f_go    = f_ready && !f_kill && !m_wait;
    assign f_redir = f_ready && f_kill;

    assign imem.need_req  = !redir_pend;
    assign imem.wr        = 1'b0;
    assign imem.addr      = pc;
    assign imem.wdata     = '0;
    assign imem.unique_id = fetch_id;
    assign imem.stall     = !f_go;
    assign imem.flush     = f_redir;

    assign dmem.need_req  = m_mem;
    assign dmem.wr        = m_store;
    assign dmem.addr      = {16'b0, m_instr.addr};
    assign dmem.wdata     = store_data;
    assign dmem.unique_id = inst_count;
    assign dmem.stall     = m_wait;
    assign dmem.flush     = !m_mem;

    // pc only moves with no fetch outstanding, so inst_addr holds during req
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc         <= RESET_PC;
            fetch_id   <= '0;
            redir_pend <= 1'b0;
        end else if (f_redir) begin
            pc         <= jump_fire ? jump_pc : redir_pc;
            fetch_id   <= fetch_id + 32'd1;
            redir_pend <= 1'b0;
        end else if (jump_fire) begin
            redir_pend <= 1'b1;
        end else if (f_go) begin
            pc       <= pc + PC_STEP;
            fetch_id <= fetch_id + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (jump_fire) begin
            redir_pc <= jump_pc;
        end
    end

    // bubble into X when fetch has nothing to hand over
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x_valid <= 1'b0;
        end else if (!m_wait) begin
            x_valid <= f_go;
        end
    end

    always_ff @(posedge clk) begin
        if (!m_wait) begin
            x_pc    <= pc;
            x_instr <= instr_t'(imem.rdata);
        end
    end

    // count gives every memory-stage instruction a fresh dmem tag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            m_valid    <= 1'b0;
            inst_count <= '0;
        end else if (!m_wait) begin
            m_valid <= x_valid;
            if (x_valid) begin
                inst_count <= inst_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!m_wait) begin
            m_pc    <= x_pc;
            m_instr <= x_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= m_valid && !m_wait;
        end
    end

    // nop and jump retire with data 0
    always_ff @(posedge clk) begin
        retire.pc <= m_pc;
        if (m_load) begin
            retire.data <= dmem.rdata;
        end else if (m_store) begin
            retire.data <= store_data;
        end else begin
            retire.data <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== port_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface port_ctrl_if;
    import mem_pkg::*;

    // from the pipeline controller
    logic  need_req;
    logic  wr;
    word_t addr;
    word_t wdata;
    word_t unique_id;
    logic  stall;
    logic  flush;

    // from the bus port
    logic  busy;
    word_t rdata;
    logic  done;

    modport port (
        input  need_req, wr, addr, wdata, unique_id, stall, flush,
        output busy, rdata, done
    );

    modport ctrl (
        output need_req, wr, addr, wdata, unique_id, stall, flush,
        input  busy, rdata, done
    );

endinterface

`default_nettype wire

// ==== rdata_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rdata_latch (
    input  logic           clk,
    input  logic           resetn,
    input  logic           stall,
    input  logic           flush,
    input  logic           data_ok,
    input  mem_pkg::word_t in,
    output mem_pkg::word_t out,
    output logic           done
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out  <= '0;
            done <= 1'b0;
        end else begin
            done <= data_ok && !flush;
            if (flush) begin
                out <= '0;
            end else if (data_ok) begin
                out <= in;
            end else if (!stall) begin
                // word consumed once the stage moves on
                out <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then check the log
rm -f sim.log build.log
verilator --binary --timing -f filelist.f --top-module tb_mem_pipeline \
    -o tb_mem_pipeline > build.log 2>&1 \
    && ./obj_dir/tb_mem_pipeline > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log; }
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// ==== sram_like_handshake.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_like_handshake (
    input  logic           clk,
    input  logic           resetn,
    input  logic           need_req,
    input  mem_pkg::word_t unique_id,
    input  logic           addr_ok,
    input  logic           data_ok,
    output logic           req,
    output logic           busy
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WAIT_ADDR = 2'd1,
        ST_WAIT_DATA = 2'd2
    } state_t;

    state_t state;
    state_t state_next;
    word_t  last_id;
    logic   new_id;

    // a tag not yet served starts a transaction
    assign new_id = need_req && (unique_id != last_id);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (new_id) begin
                    state_next = ST_WAIT_ADDR;
                end
            end
            ST_WAIT_ADDR: begin
                if (addr_ok) begin
                    state_next = ST_WAIT_DATA;
                end
            end
            ST_WAIT_DATA: begin
                if (data_ok) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= ST_IDLE;
            last_id <= ID_NONE;
        end else begin
            state <= state_next;
            if (state == ST_IDLE && new_id) begin
                last_id <= unique_id;
            end
        end
    end

    // req held until the slave takes the address
    assign req = (state == ST_WAIT_ADDR);

    // new_id term keeps the stage from moving on with old data
    assign busy = (state != ST_IDLE) || new_id;

endmodule

`default_nettype wire

// ==== tb_mem_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_pipeline;
    import mem_pkg::*;

    logic  clk = 1'b0;
    logic  resetn = 1'b0;
    logic  inst_req;
    word_t inst_addr;
    word_t inst_rdata = '0;
    logic  inst_addr_ok = 1'b0;
    logic  inst_data_ok = 1'b0;
    logic  data_req;
    logic  data_wr;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata = '0;
    logic  data_addr_ok = 1'b0;
    logic  data_data_ok = 1'b0;
    logic  debug_wb_valid;
    word_t debug_wb_pc;
    word_t debug_wb_data;

    // file image with program at 0x00, data at 0x10 and expected retires from 0x20
    word_t input_mem [0:63];
    word_t prog_mem [0:15];
    word_t data_mem [0:15];
    word_t exp_pc_q [$];
    word_t exp_data_q [$];
    word_t exp_pc;
    word_t exp_data;
    int    exp_count;

    // slave phase is 0 idle, 1 address wait or 2 data wait
    logic [1:0]  i_phase;
    logic [1:0]  i_wait;
    word_t       i_addr_q;
    logic [1:0]  d_phase;
    logic [1:0]  d_wait;
    word_t       d_addr_q;
    logic        d_wr_q;
    logic [31:0] rng = 32'ha3f2;

    int   errors = 0;
    int   protocol_errors = 0;
    int   retired = 0;
    int   reset_edges = 0;
    int   run_cycles = 0;
    logic first_fetch_seen = 1'b0;

    mem_pipeline mem_pipeline_i (
        .clk            (clk),
        .resetn         (resetn),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .inst_rdata     (inst_rdata),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .data_req       (data_req),
        .data_wr        (data_wr),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata),
        .data_addr_ok   (data_addr_ok),
        .data_data_ok   (data_data_ok),
        .debug_wb_valid (debug_wb_valid),
        .debug_wb_pc    (debug_wb_pc),
        .debug_wb_data  (debug_wb_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic finish_run();
        $display("retired %0d of %0d, check errors %0d, protocol errors %0d",
                 retired, exp_count, errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        $readmemh("test_input.txt", input_mem);
        for (int k = 0; k < 16; k++) begin
            prog_mem[k] = input_mem[k];
        end
        exp_count = int'(input_mem[32]);
        for (int k = 0; k < exp_count; k++) begin
            exp_pc_q.push_back(input_mem[33 + 2 * k]);
            exp_data_q.push_back(input_mem[34 + 2 * k]);
        end
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
    end

    // sram-like slaves for both buses with 0 to 3 extra cycles per phase
    always @(posedge clk) begin
        inst_addr_ok <= 1'b0;
        inst_data_ok <= 1'b0;
        data_addr_ok <= 1'b0;
        data_data_ok <= 1'b0;
        if (!resetn) begin
            i_phase <= 2'd0;
            d_phase <= 2'd0;
            for (int k = 0; k < 16; k++) begin
                data_mem[k] <= input_mem[16 + k];
            end
        end else begin
            rng = next_random(rng);
            if ((i_phase == 2'd0 && inst_req) || (i_phase == 2'd1 && inst_req)) begin
                if ((i_phase == 2'd0 && rng[1:0] == 2'd0)
                        || (i_phase == 2'd1 && i_wait == 2'd0)) begin
                    inst_addr_ok <= 1'b1;
                    i_addr_q     <= inst_addr;
                    i_wait       <= rng[3:2];
                    i_phase      <= 2'd2;
                end else begin
                    i_wait  <= (i_phase == 2'd0) ? rng[1:0] - 2'd1 : i_wait - 2'd1;
                    i_phase <= 2'd1;
                end
            end else if (i_phase == 2'd1) begin
                $display("inst bus: req dropped before addr_ok");
                protocol_errors++;
                i_phase <= 2'd0;
            end else if (i_phase == 2'd2) begin
                if (inst_req && !inst_addr_ok) begin
                    $display("inst bus: req raised while a transaction is outstanding");
                    protocol_errors++;
                end
                if (i_wait == 2'd0) begin
                    inst_data_ok <= 1'b1;
                    inst_rdata   <= prog_mem[i_addr_q[5:2]];
                    i_phase      <= 2'd0;
                end else begin
                    i_wait <= i_wait - 2'd1;
                end
            end

            rng = next_random(rng);
            if ((d_phase == 2'd0 && data_req) || (d_phase == 2'd1 && data_req)) begin
                if ((d_phase == 2'd0 && rng[1:0] == 2'd0)
                        || (d_phase == 2'd1 && d_wait == 2'd0)) begin
                    data_addr_ok <= 1'b1;
                    d_addr_q     <= data_addr;
                    d_wr_q       <= data_wr;
                    d_wait       <= rng[3:2];
                    d_phase      <= 2'd2;
                    // store lands when the address is taken
                    if (data_wr) begin
                        data_mem[data_addr[5:2]] <= data_wdata;
                    end
                end else begin
                    d_wait  <= (d_phase == 2'd0) ? rng[1:0] - 2'd1 : d_wait - 2'd1;
                    d_phase <= 2'd1;
                end
            end else if (d_phase == 2'd1) begin
                $display("data bus: req dropped before addr_ok");
                protocol_errors++;
                d_phase <= 2'd0;
            end else if (d_phase == 2'd2) begin
                if (data_req && !data_addr_ok) begin
                    $display("data bus: req raised while a transaction is outstanding");
                    protocol_errors++;
                end
                if (d_wait == 2'd0) begin
                    data_data_ok <= 1'b1;
                    data_rdata   <= d_wr_q ? '0 : data_mem[d_addr_q[5:2]];
                    d_phase      <= 2'd0;
                end else begin
                    d_wait <= d_wait - 2'd1;
                end
            end
        end
    end

    // reset values, first fetch address, retire trace and timeout
    always @(posedge clk) begin
        if (!resetn) begin
            if (reset_edges > 0) begin
                if (inst_req !== 1'b0) begin
                    report_mismatch("reset inst_req", '0, 32'(inst_req));
                end
                if (data_req !== 1'b0) begin
                    report_mismatch("reset data_req", '0, 32'(data_req));
                end
                if (data_wr !== 1'b0) begin
                    report_mismatch("reset data_wr", '0, 32'(data_wr));
                end
                if (debug_wb_valid !== 1'b0) begin
                    report_mismatch("reset debug_wb_valid", '0, 32'(debug_wb_valid));
                end
            end
            reset_edges++;
        end else begin
            run_cycles++;
            if (inst_req === 1'b1 && !first_fetch_seen) begin
                first_fetch_seen = 1'b1;
                if (inst_addr !== RESET_PC) begin
                    report_mismatch("first inst_addr", RESET_PC, inst_addr);
                end
            end
            if (debug_wb_valid === 1'b1 && exp_pc_q.size() > 0) begin
                exp_pc = exp_pc_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (debug_wb_pc !== exp_pc) begin
                    report_mismatch($sformatf("retire %0d pc", retired), exp_pc, debug_wb_pc);
                end
                if (debug_wb_data !== exp_data) begin
                    report_mismatch($sformatf("retire %0d data", retired), exp_data,
                                    debug_wb_data);
                end
                retired++;
            end
            if (retired == exp_count) begin
                finish_run();
            end else if (run_cycles >= exp_count * 20 + 100) begin
                $display("timeout: %0d of %0d instructions retired in %0d cycles",
                         retired, exp_count, run_cycles);
                errors++;
                finish_run();
            end
        end
    end

endmodule

`default_nettype wire

// ==== test_input.txt ====
// @00 program words by pc/4, @10 initial data words by addr/4
// @20 expected retire count, then one pair per line: pc data
@00
00000000 // 0x00 nop
00000000 // 0x04 nop
40000008 // 0x08 load 0x08
92340010 // 0x0c store 0x1234 to 0x10
40000010 // 0x10 load 0x10
C0000024 // 0x14 jump 0x24
BFFF0010 // 0x18 store 0x3fff to 0x10, skipped
00000000 // 0x1c nop, skipped
00000000 // 0x20 nop, skipped
40000010 // 0x24 load 0x10
8ABC0004 // 0x28 store 0x0abc to 0x04
40000004 // 0x2c load 0x04
4000003C // 0x30 load 0x3c
00000000 // 0x34 nop
C0000038 // 0x38 jump 0x38
00000000 // 0x3c nop
@10
DADA0000 DADA0004 DADA0008 DADA000C DADA0010 DADA0014 DADA0018 DADA001C
DADA0020 DADA0024 DADA0028 DADA002C DADA0030 DADA0034 DADA0038 DADA003C
@20
0000000B
00000000 00000000
00000004 00000000
00000008 DADA0008
0000000C 00001234
00000010 00001234
00000014 00000000
00000024 00001234
00000028 00000ABC
0000002C 00000ABC
00000030 DADA003C
00000034 00000000
